/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_char_recognition
FILELIST = vlog.f
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* logic/cell_counter_array.sv */
`timescale 1ns/10ps
`include "char_rec_cfg.svh"

module cell_counter_array (
   input  logic                i_pixelclk,
   input  logic                i_reset_n,
   input  logic                i_clear,
   input  logic                i_decide,
   input  grid_pkg::cell_hit_s i_hit,
   input  grid_pkg::cnt_t      i_threshold,
   output grid_pkg::char_vec_t o_cells
);

   // one dark-pixel counter and one decided bit per cell.
   for (genvar k = 0; k < `GRID_CELLS; k++) begin : g_cell
      grid_pkg::cnt_t count;
      logic           bump;
      logic           cell_q;

      // the hit flag already carries the dark test.
      assign bump = i_hit.hit && (i_hit.idx == grid_pkg::cell_idx_t'(k));

      always_ff @(posedge i_pixelclk or negedge i_reset_n) begin
         if (!i_reset_n) begin
            count <= '0;
         end else if (i_clear) begin
            count <= '0;
         end else if (bump) begin
            count <= count + 1'b1;
         end
      end

      always_ff @(posedge i_pixelclk or negedge i_reset_n) begin
         if (!i_reset_n) begin
            cell_q <= 1'b0;
         end else if (i_decide) begin
            cell_q <= (count > i_threshold);  // strictly more than half the area.
         end
      end

      // the top-left cell lands in the most significant bit.
      assign o_cells[`GRID_CELLS-1-k] = cell_q;

      // a cell larger than the counter range would wrap its count to zero.
      a_no_wrap: assert property (
         @(posedge i_pixelclk) disable iff (!i_reset_n)
         (bump && !i_clear) |-> (count != '1)
      );
   end

endmodule

/* logic/char_rec_cfg.svh */
`ifndef CHAR_REC_CFG_SVH
`define CHAR_REC_CFG_SVH

// the character box is cut into GRID_COLS by GRID_ROWS cells.
`define GRID_COLS  5
`define GRID_ROWS  8
`define GRID_CELLS (`GRID_COLS * `GRID_ROWS)

`define COORD_W    12
`define CNT_W      12
`define RGB_W      24

// only pure white counts as a light pixel.
`define WHITE_RGB  {`RGB_W{1'b1}}

`endif

/* logic/char_recognition.sv */
`timescale 1ns/10ps
`include "char_rec_cfg.svh"

module char_recognition (
   input  logic                pixelclk,
   input  logic                reset_n,
   input  video_pkg::pixel_s   i_pixel,
   input  video_pkg::box_s     i_box,
   output grid_pkg::char_vec_t o_char
);

   logic                clear;
   logic                decide;
   logic                publish;
   grid_pkg::cell_hit_s hit;
   grid_pkg::cnt_t      threshold;
   grid_pkg::char_vec_t cells;

   frame_sequencer u_frame_sequencer (
      .i_pixelclk (pixelclk),
      .i_reset_n  (reset_n),
      .i_vsync    (i_pixel.vsync),
      .o_clear    (clear),
      .o_decide   (decide),
      .o_publish  (publish)
   );

   grid_geometry u_grid_geometry (
      .i_pixelclk  (pixelclk),
      .i_reset_n   (reset_n),
      .i_clear     (clear),
      .i_pixel     (i_pixel),
      .i_box       (i_box),
      .o_hit       (hit),
      .o_threshold (threshold)
   );

   cell_counter_array u_cell_counter_array (
      .i_pixelclk  (pixelclk),
      .i_reset_n   (reset_n),
      .i_clear     (clear),
      .i_decide    (decide),
      .i_hit       (hit),
      .i_threshold (threshold),
      .o_cells     (cells)
   );

   // the vector holds from one publish to the next.
   always_ff @(posedge pixelclk or negedge reset_n) begin
      if (!reset_n) begin
         o_char <= '0;
      end else if (publish) begin
         o_char <= cells;
      end
   end

endmodule

/* logic/frame_sequencer.sv */
`timescale 1ns/10ps
`include "char_rec_cfg.svh"

module frame_sequencer (
   input  logic i_pixelclk,
   input  logic i_reset_n,
   input  logic i_vsync,
   output logic o_clear,
   output logic o_decide,
   output logic o_publish
);

   logic             vsync_q;
   grid_pkg::phase_e phase_q;
   grid_pkg::phase_e phase_d;

   always_ff @(posedge i_pixelclk or negedge i_reset_n) begin
      if (!i_reset_n) begin
         vsync_q <= 1'b0;
         phase_q <= grid_pkg::PH_IDLE;
      end else begin
         vsync_q <= i_vsync;
         phase_q <= phase_d;
      end
   end

   assign o_clear  = i_vsync & ~vsync_q;  // rising vsync starts a frame.
   assign o_decide = ~i_vsync & vsync_q;

   always_comb begin
      phase_d = phase_q;
      case (phase_q)
         grid_pkg::PH_IDLE:    if (o_clear) phase_d = grid_pkg::PH_ACTIVE;
         grid_pkg::PH_ACTIVE:  if (o_decide) phase_d = grid_pkg::PH_PUBLISH;
         // a vsync pulse right after the publish opens the next frame at once.
         grid_pkg::PH_PUBLISH: phase_d = o_clear ? grid_pkg::PH_ACTIVE : grid_pkg::PH_IDLE;
         default:              phase_d = grid_pkg::PH_IDLE;
      endcase
   end

   // the publish cycle is the single cycle spent in PH_PUBLISH.
   assign o_publish = (phase_q == grid_pkg::PH_PUBLISH);

   // a falling vsync always belongs to a frame that was opened by a clear.
   a_decide_not_idle: assert property (
      @(posedge i_pixelclk) disable iff (!i_reset_n)
      o_decide |-> (phase_q != grid_pkg::PH_IDLE)
   );

endmodule

/* logic/grid_geometry.sv */
`timescale 1ns/10ps
`include "char_rec_cfg.svh"

module grid_geometry (
   input  logic                i_pixelclk,
   input  logic                i_reset_n,
   input  logic                i_clear,
   input  video_pkg::pixel_s   i_pixel,
   input  video_pkg::box_s     i_box,
   output grid_pkg::cell_hit_s o_hit,
   output grid_pkg::cnt_t      o_threshold
);

   localparam int SPAN_W = `COORD_W + 4;
   localparam int AREA_W = 2 * `COORD_W;
   localparam int COL_W  = $clog2(`GRID_COLS);
   localparam int ROW_W  = $clog2(`GRID_ROWS);

   video_pkg::box_s      box_q;
   grid_pkg::col_edges_t col_edge;
   grid_pkg::row_edges_t row_edge;
   logic [SPAN_W-1:0]    span_x;
   logic [SPAN_W-1:0]    span_y;
   logic [AREA_W-1:0]    cell_area;
   logic [COL_W-1:0]     col_idx;
   logic [ROW_W-1:0]     row_idx;
   logic                 col_ok;
   logic                 row_ok;
   logic                 dark;
   grid_pkg::cell_idx_t  cell_idx;

   // the box is taken once per frame at the rise of vsync.
   always_ff @(posedge i_pixelclk or negedge i_reset_n) begin
      if (!i_reset_n) begin
         box_q <= '0;
      end else if (i_clear) begin
         box_q <= i_box;
      end
   end

   assign span_x = SPAN_W'(box_q.right - box_q.left);
   assign span_y = SPAN_W'(box_q.bottom - box_q.top);

   for (genvar c = 0; c <= `GRID_COLS; c++) begin : g_col_edge
      logic [SPAN_W-1:0] scaled;
      assign scaled      = span_x * SPAN_W'(c) / SPAN_W'(`GRID_COLS);
      assign col_edge[c] = box_q.left + scaled[`COORD_W-1:0];
   end

   for (genvar r = 0; r <= `GRID_ROWS; r++) begin : g_row_edge
      logic [SPAN_W-1:0] scaled;
      assign scaled      = span_y * SPAN_W'(r) / SPAN_W'(`GRID_ROWS);
      assign row_edge[r] = box_q.top + scaled[`COORD_W-1:0];
   end

   // pixels on an edge line belong to no cell.
   always_comb begin
      col_ok  = 1'b0;
      col_idx = '0;
      for (int c = 0; c < `GRID_COLS; c++) begin
         if (i_pixel.hcount > col_edge[c] && i_pixel.hcount < col_edge[c+1]) begin
            col_ok  = 1'b1;
            col_idx = COL_W'(c);
         end
      end
   end

   always_comb begin
      row_ok  = 1'b0;
      row_idx = '0;
      for (int r = 0; r < `GRID_ROWS; r++) begin
         if (i_pixel.vcount > row_edge[r] && i_pixel.vcount < row_edge[r+1]) begin
            row_ok  = 1'b1;
            row_idx = ROW_W'(r);
         end
      end
   end

   assign dark     = (i_pixel.rgb != `WHITE_RGB);
   assign cell_idx = grid_pkg::cell_idx_t'(row_idx) * grid_pkg::cell_idx_t'(`GRID_COLS)
                   + grid_pkg::cell_idx_t'(col_idx);

   assign o_hit = '{hit: dark && col_ok && row_ok, idx: cell_idx};

   // half the area of the top-left cell, measured between its edges.
   assign cell_area   = AREA_W'(col_edge[1] - col_edge[0]) * AREA_W'(row_edge[1] - row_edge[0]);
   assign o_threshold = grid_pkg::cnt_t'(cell_area >> 1);

   // a hit names a real cell and its pixel lies strictly inside the latched box.
   a_hit_in_range: assert property (
      @(posedge i_pixelclk) disable iff (!i_reset_n)
      o_hit.hit |-> (o_hit.idx < grid_pkg::cell_idx_t'(`GRID_CELLS))
                    && (i_pixel.hcount > box_q.left) && (i_pixel.hcount < box_q.right)
                    && (i_pixel.vcount > box_q.top) && (i_pixel.vcount < box_q.bottom)
   );

endmodule

/* logic/grid_pkg.sv */
`include "char_rec_cfg.svh"

package grid_pkg;

   typedef logic [`CNT_W-1:0]               cnt_t;
   typedef logic [$clog2(`GRID_CELLS)-1:0]  cell_idx_t;
   typedef logic [`COORD_W-1:0]             edge_t;

   // the outer box edges sit at index 0 and at the last index.
   typedef edge_t [`GRID_COLS:0] col_edges_t;
   typedef edge_t [`GRID_ROWS:0] row_edges_t;

   typedef struct packed {
      logic      hit;
      cell_idx_t idx;  // row-major from the top-left cell.
   } cell_hit_s;

   typedef logic [`GRID_CELLS-1:0] char_vec_t;  // cell k sits at bit GRID_CELLS-1-k.

   typedef enum logic [1:0] {
      PH_IDLE    = 2'd0,
      PH_ACTIVE  = 2'd1,
      PH_PUBLISH = 2'd2
   } phase_e;

endpackage

/* logic/video_pkg.sv */
`include "char_rec_cfg.svh"

package video_pkg;

   typedef logic [`RGB_W-1:0]   rgb_t;
   typedef logic [`COORD_W-1:0] coord_t;

   // one pixel of the stream with its screen position.
   typedef struct packed {
      rgb_t   rgb;
      logic   vsync;
      coord_t hcount;
      coord_t vcount;
   } pixel_s;

   typedef struct packed {
      coord_t left;
      coord_t right;
      coord_t top;
      coord_t bottom;
   } box_s;

endpackage

/* sim/tb_char_tasks.svh */
`ifndef TB_CHAR_TASKS_SVH
`define TB_CHAR_TASKS_SVH

task automatic stop_run();
   $display("STATUS: FAIL");
   $fatal(1, "testbench stopped at the first error");
endtask

task automatic report_mismatch(input string test, input grid_pkg::char_vec_t exp,
                               input grid_pkg::char_vec_t act);
   $display("ERROR %s: expected %h actual %h", test, exp, act);
   stop_run();
endtask

task automatic report_problem(input string what);
   $display("%s", what);
   stop_run();
endtask

// cell index of a box position, or -1 on an edge line or outside the box.
function automatic int cell_of(input int h, input int v);
   int rel_h;
   int rel_v;
   rel_h = h - BOX_LEFT;
   rel_v = v - BOX_TOP;
   if (rel_h <= 0 || rel_v <= 0 || h >= BOX_RIGHT || v >= BOX_BOTTOM) return -1;
   if (rel_h % CELL_W == 0 || rel_v % CELL_H == 0) return -1;
   return (rel_v / CELL_H) * `GRID_COLS + rel_h / CELL_W;
endfunction

function automatic logic is_dark(input int mode, input grid_pkg::char_vec_t pick,
                                 input int h, input int v);
   int k;
   k = cell_of(h, v);
   if (mode == MODE_DARK) return 1'b1;
   if (mode == MODE_EDGES) return k < 0;
   if (mode == MODE_PATTERN && k >= 0) return pick[`GRID_CELLS-1-k];
   return 1'b0;
endfunction

function automatic grid_pkg::char_vec_t expected_vector();
   grid_pkg::char_vec_t vec;
   vec = '0;
   for (int k = 0; k < `GRID_CELLS; k++) begin
      vec[`GRID_CELLS-1-k] = counts[k] > HALF_AREA;  // strictly more than half a cell.
   end
   return vec;
endfunction

task automatic draw_frame(input string test, input int mode, input grid_pkg::char_vec_t pick);
   grid_pkg::char_vec_t held;
   logic                dark;
   int                  k;
   logic [31:0]         rnd;
   held = char_vec;
   for (int c = 0; c < `GRID_CELLS; c++) begin
      counts[c] = 0;
   end
   pixel.vsync = 1'b1;
   @(negedge pixelclk);  // the box is latched in this clear cycle.
   for (int v = BOX_TOP; v <= BOX_BOTTOM; v++) begin
      for (int h = BOX_LEFT; h <= BOX_RIGHT; h++) begin
         dark = is_dark(mode, pick, h, v);
         k    = cell_of(h, v);
         rnd  = $random(seed);
         pixel.hcount = video_pkg::coord_t'(h);
         pixel.vcount = video_pkg::coord_t'(v);
         pixel.rgb    = dark ? {rnd[23:1], 1'b0} : `WHITE_RGB;  // any non-white is dark.
         if (dark && k >= 0) counts[k]++;
         @(negedge pixelclk);
         assert (char_vec == held) else report_mismatch({test, " hold"}, held, char_vec);
      end
   end
   pixel = '{rgb: `WHITE_RGB, vsync: 1'b0, hcount: '0, vcount: '0};
endtask

// waits for o_char to change, or only up to the publish edge when no change is due.
task automatic wait_publish(input string test, input grid_pkg::char_vec_t held,
                            input logic change_due);
   int n;
   n = 0;
   while (char_vec == held && (change_due || n < PUBLISH_CYCLES)) begin
      @(negedge pixelclk);
      n++;
      if (n >= TIMEOUT_CYCLES) report_problem({test, ": no publish within the timeout"});
   end
   assert (n == PUBLISH_CYCLES)
      else report_problem({test, ": o_char did not change at the publish edge"});
endtask

task automatic run_frame_check(input string test, input int mode,
                               input grid_pkg::char_vec_t pick);
   grid_pkg::char_vec_t held;
   grid_pkg::char_vec_t exp;
   held = char_vec;
   draw_frame(test, mode, pick);
   exp = expected_vector();
   wait_publish(test, held, exp != held);
   assert (char_vec == exp) else report_mismatch(test, exp, char_vec);
endtask

task automatic random_pick(output grid_pkg::char_vec_t pick);
   logic [31:0] rnd;
   for (int k = 0; k < `GRID_CELLS; k++) begin
      rnd     = $random(seed);
      pick[k] = rnd[0];
   end
endtask

task automatic test_reset_value();
   assert (char_vec == '0) else report_mismatch("reset_value", '0, char_vec);
endtask

task automatic test_all_white();
   run_frame_check("all_white", MODE_WHITE, '0);
endtask

task automatic test_all_dark();
   run_frame_check("all_dark", MODE_DARK, '0);
endtask

task automatic test_random_pattern();
   grid_pkg::char_vec_t pick;
   random_pick(pick);
   run_frame_check("random_pattern", MODE_PATTERN, pick);
endtask

task automatic test_edge_lines();
   run_frame_check("edge_lines", MODE_EDGES, '0);
endtask

// the inverse pattern only shows up whole if the counters were cleared.
task automatic test_replace_vector();
   grid_pkg::char_vec_t pick;
   random_pick(pick);
   run_frame_check("replace_first", MODE_PATTERN, pick);
   run_frame_check("replace_second", MODE_PATTERN, ~pick);
endtask

`endif

/* sim/tb_char_recognition.sv */
`timescale 1ns/10ps
`include "char_rec_cfg.svh"

module tb_char_recognition;

   // test box of 50 by 80 pixels, so every cell is 10 by 10 between edges.
   localparam int BOX_LEFT   = 0;
   localparam int BOX_RIGHT  = 50;
   localparam int BOX_TOP    = 0;
   localparam int BOX_BOTTOM = 80;
   localparam int CELL_W     = (BOX_RIGHT - BOX_LEFT) / `GRID_COLS;
   localparam int CELL_H     = (BOX_BOTTOM - BOX_TOP) / `GRID_ROWS;
   localparam int HALF_AREA  = CELL_W * CELL_H / 2;

   localparam int PUBLISH_CYCLES = 2;  // rising edges from the first low vsync sample.
   localparam int TIMEOUT_CYCLES = 10;

   // colour patterns that a frame can be drawn with.
   localparam int MODE_WHITE   = 0;
   localparam int MODE_DARK    = 1;
   localparam int MODE_PATTERN = 2;
   localparam int MODE_EDGES   = 3;

   logic                pixelclk;
   logic                reset_n;
   video_pkg::pixel_s   pixel;
   video_pkg::box_s     box;
   grid_pkg::char_vec_t char_vec;

   int seed;
   int counts [`GRID_CELLS];  // dark pixels driven into each cell interior.

   char_recognition dut0 (
      .pixelclk (pixelclk),
      .reset_n  (reset_n),
      .i_pixel  (pixel),
      .i_box    (box),
      .o_char   (char_vec)
   );

   initial begin
      pixelclk = 1'b0;
      forever #50 pixelclk = ~pixelclk;
   end

   `include "tb_char_tasks.svh"

   initial begin
      seed    = 32'ha996_12a4;
      reset_n = 1'b0;
      pixel   = '{rgb: `WHITE_RGB, vsync: 1'b0, hcount: '0, vcount: '0};
      box     = '{left:   video_pkg::coord_t'(BOX_LEFT),
                  right:  video_pkg::coord_t'(BOX_RIGHT),
                  top:    video_pkg::coord_t'(BOX_TOP),
                  bottom: video_pkg::coord_t'(BOX_BOTTOM)};
      for (int k = 0; k < `GRID_CELLS; k++) begin
         counts[k] = 0;
      end

      repeat (2) @(negedge pixelclk);
      reset_n = 1'b1;

      test_reset_value();
      test_all_white();
      test_all_dark();
      test_random_pattern();
      test_edge_lines();
      test_replace_vector();

      $display("STATUS: PASS");
      $finish;
   end

endmodule

/* vlog.f */
+incdir+logic
+incdir+sim
logic/video_pkg.sv
logic/grid_pkg.sv
logic/frame_sequencer.sv
logic/grid_geometry.sv
logic/cell_counter_array.sv
logic/char_recognition.sv
sim/tb_char_recognition.sv
